//--- Makefile
# Verilator build and run of the page allocator testbench

.PHONY: sim clean

sim:
	verilator --binary --timing --assert --timescale 1ns/1ps \
		--top-module pam_tb -f files.f -o pam_sim
	./obj_dir/pam_sim

clean:
	rm -rf obj_dir

//--- design/pam_bank.sv
// Page pool
`timescale 1ns/1ps
`default_nettype none

`include "pam_consts.svh"

module pam_bank
(
	input  wire logic                 clk,
	input  wire logic                 rst,
	input  wire logic                 cmd_valid_i,
	input  wire pam_cmd_pkg::pam_op_e cmd_op_i,
	input  wire pam_cmd_pkg::page_t   cmd_page_i,
	output logic                      ready_o,
	output logic                      done_o,
	output pam_cmd_pkg::page_t        page_o,
	output logic                      full_o
);

	import pam_cmd_pkg::*;
	import pam_bank_pkg::*;

	localparam int BIT_W  = $clog2(`PAM_WORD_BITS);
	localparam int WIDX_W = $bits(word_idx_t);

	// Page bitmap, one bit per page
	map_word_t map_mem [`PAM_WORDS];

	bank_state_e state;
	word_idx_t   word_q;
	logic        from_cmd_q;

	// Working copy of the word under modification
	map_word_t         map_q;
	logic [BIT_W-1:0]  bit_q;

	// Scan result for map_q
	logic              any_clear;
	logic [BIT_W-1:0]  free_bit;

	// Page 0 reads back as used whatever the map holds
	map_word_t first_mask;
	logic      mem_we;
	map_word_t mem_wdata;

	assign ready_o    = (state == ST_IDLE);
	assign first_mask = map_word_t'(word_q == '0);

	// ======================================================================
	// Free bit search
	// ======================================================================

	// Ascending loop, so the highest clear bit wins
	always_comb
	begin
		any_clear = 1'b0;
		free_bit  = '0;
		for (int n = 0; n < `PAM_WORD_BITS; n++)
		begin
			if (!map_q[n])
			begin
				any_clear = 1'b1;
				free_bit  = BIT_W'(n);
			end
		end
	end

	// ======================================================================
	// Control FSM
	// ======================================================================

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			// Map is wiped by the clear loop, one word per cycle
			state      <= ST_CLEAR;
			word_q     <= '0;
			from_cmd_q <= 1'b0;
			done_o     <= 1'b0;
			page_o     <= '0;
			full_o     <= 1'b0;
		end
		else
		begin
			done_o <= 1'b0;
			case (state)
			ST_CLEAR:
			begin
				word_q <= word_q + word_idx_t'(1);
				if (word_q == word_idx_t'(`PAM_WORDS - 1))
				begin
					// Power-up clear completes silently, free-all reports back
					done_o     <= from_cmd_q;
					from_cmd_q <= 1'b0;
					page_o     <= '0;
					full_o     <= 1'b0;
					state      <= ST_IDLE;
				end
			end
			ST_IDLE:
				if (cmd_valid_i)
				begin
					case (cmd_op_i)
					OP_ALLOC:
					begin
						word_q <= '0;
						state  <= ST_ALLOC_READ;
					end
					OP_FREE:
					begin
						word_q <= cmd_page_i[BIT_W +: WIDX_W];
						state  <= ST_FREE_READ;
					end
					OP_FREEALL:
					begin
						word_q     <= '0;
						from_cmd_q <= 1'b1;
						state      <= ST_CLEAR;
					end
					default:
						// Nothing to do, complete at once
						done_o <= 1'b1;
					endcase
				end
			ST_ALLOC_READ:
				state <= ST_ALLOC_SCAN;
			ST_ALLOC_SCAN:
				if (any_clear)
					state <= ST_ALLOC_SET;
				else if (word_q == word_idx_t'(`PAM_WORDS - 1))
					state <= ST_ALLOC_FULL;
				else
				begin
					// Word is full, move on to the next one
					word_q <= word_q + word_idx_t'(1);
					state  <= ST_ALLOC_READ;
				end
			ST_ALLOC_SET:
				state <= ST_ALLOC_WRITE;
			ST_ALLOC_WRITE:
			begin
				page_o <= {word_q, bit_q};
				full_o <= 1'b0;
				done_o <= 1'b1;
				state  <= ST_IDLE;
			end
			ST_ALLOC_FULL:
			begin
				// No page left, hand back the reserved page 0
				page_o <= '0;
				full_o <= 1'b1;
				done_o <= 1'b1;
				state  <= ST_IDLE;
			end
			ST_FREE_READ:
				state <= ST_FREE_CLEAR;
			ST_FREE_CLEAR:
				state <= ST_FREE_WRITE;
			ST_FREE_WRITE:
			begin
				done_o <= 1'b1;
				state  <= ST_IDLE;
			end
			default:
				state <= ST_IDLE;
			endcase
		end
	end

	// ======================================================================
	// Bitmap datapath
	// ======================================================================

	assign mem_we = !rst &&
		(state == ST_CLEAR || state == ST_ALLOC_WRITE || state == ST_FREE_WRITE);
	assign mem_wdata = (state == ST_CLEAR) ? '0 : map_q;

	always_ff @(posedge clk)
	begin
		if (mem_we)
			map_mem[word_q] <= mem_wdata;
		case (state)
		ST_IDLE:
			// Bit index of a free request, replaced by the scan on alloc
			bit_q <= cmd_page_i[BIT_W-1:0];
		ST_ALLOC_READ,
		ST_FREE_READ:
			map_q <= map_mem[word_q] | first_mask;
		ST_ALLOC_SCAN:
			bit_q <= free_bit;
		ST_ALLOC_SET:
			map_q[bit_q] <= 1'b1;
		ST_FREE_CLEAR:
			map_q[bit_q] <= 1'b0;
		default:
			map_q <= map_q;
		endcase
	end

	// Slave only starts a pool that reports ready
	a_cmd_in_idle: assert property (@(posedge clk) disable iff (rst)
		cmd_valid_i |-> state == ST_IDLE);

endmodule

`default_nettype wire

//--- design/pam_bank_pkg.sv
// Page pool internal types
`default_nettype none

`include "pam_consts.svh"

package pam_bank_pkg;

	// Pool FSM, clear loop plus read-modify-write paths
	typedef enum logic [3:0]
	{
		ST_CLEAR,
		ST_IDLE,
		ST_ALLOC_READ,
		ST_ALLOC_SCAN,
		ST_ALLOC_SET,
		ST_ALLOC_WRITE,
		ST_ALLOC_FULL,
		ST_FREE_READ,
		ST_FREE_CLEAR,
		ST_FREE_WRITE
	} bank_state_e;

	// One word of the page bitmap, a set bit marks a used page
	typedef logic [`PAM_WORD_BITS-1:0] map_word_t;

	// Index of a bitmap word
	typedef logic [$clog2(`PAM_WORDS)-1:0] word_idx_t;

endpackage

`default_nettype wire

//--- design/pam_cmd_pkg.sv
// Page allocator bus types
`default_nettype none

`include "pam_consts.svh"

package pam_cmd_pkg;

	// Command opcode, carried in CMD write data bits 9:8
	typedef enum logic [1:0]
	{
		OP_NOP     = 2'd0,
		OP_ALLOC   = 2'd1,
		OP_FREE    = 2'd2,
		OP_FREEALL = 2'd3
	} pam_op_e;

	// Register selector, taken from adr_i bit 2
	typedef enum logic
	{
		REG_CMD    = 1'b0,
		REG_RESULT = 1'b1
	} pam_reg_e;

	// Page number, upper bits are the map word, lower bits the bit in it
	typedef logic [$clog2(`PAM_PAGES)-1:0] page_t;

	// Bank index, taken from adr_i bits 4:3
	typedef logic [$clog2(`PAM_BANKS)-1:0] bank_id_t;

endpackage

`default_nettype wire

//--- design/pam_consts.svh
// Page allocator constants
`ifndef PAM_CONSTS_SVH
`define PAM_CONSTS_SVH

// ======================================================================
// Pool geometry
// ======================================================================

// Pages in one pool, page 0 included
`define PAM_PAGES 256

// Width of one bitmap word
`define PAM_WORD_BITS 32

// Bitmap words per pool, PAM_PAGES / PAM_WORD_BITS
`define PAM_WORDS 8

// ======================================================================
// System shape
// ======================================================================

// Independent pools, one per address-space bank
`define PAM_BANKS 4

// Wishbone data path width
`define PAM_BUS_W 32

`endif

//--- design/pam_result_collect.sv
// Page allocator result registers
`timescale 1ns/1ps
`default_nettype none

`include "pam_consts.svh"

module pam_result_collect
(
	input  wire logic                                          clk,
	input  wire logic                                          rst,
	input  wire logic [`PAM_BANKS-1:0]                         done_i,
	input  wire logic [`PAM_BANKS*$bits(pam_cmd_pkg::page_t)-1:0] page_i,
	input  wire logic [`PAM_BANKS-1:0]                         full_i,
	input  wire logic [`PAM_BANKS-1:0]                         busy_i,
	input  wire pam_cmd_pkg::bank_id_t                         rd_sel_i,
	output logic [`PAM_BUS_W-1:0]                              dat_o
);

	import pam_cmd_pkg::*;

	localparam int PAGE_W = $bits(page_t);

	// RESULT word layout, page sits in the low bits
	localparam int FULL_BIT = 8;
	localparam int BUSY_BIT = 9;

	// Last outcome of each pool
	page_t                 page_q [`PAM_BANKS];
	logic [`PAM_BANKS-1:0] full_q;

	// ======================================================================
	// Completion capture
	// ======================================================================

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			for (int b = 0; b < `PAM_BANKS; b++)
				page_q[b] <= '0;
			full_q <= '0;
		end
		else
		begin
			// Each pool updates only its own entry
			for (int b = 0; b < `PAM_BANKS; b++)
			begin
				if (done_i[b])
				begin
					page_q[b] <= page_i[b*PAGE_W +: PAGE_W];
					full_q[b] <= full_i[b];
				end
			end
		end
	end

	// Read data for the latched bank, busy comes live from the pool
	always_comb
	begin
		dat_o             = '0;
		dat_o[PAGE_W-1:0] = page_q[rd_sel_i];
		dat_o[FULL_BIT]   = full_q[rd_sel_i];
		dat_o[BUSY_BIT]   = busy_i[rd_sel_i];
	end

	// One command at a time, so completions never overlap
	a_single_done: assert property (@(posedge clk) disable iff (rst)
		$onehot0(done_i));

endmodule

`default_nettype wire

//--- design/pam_top.sv
// Page allocator top level
`timescale 1ns/1ps
`default_nettype none

`include "pam_consts.svh"

module pam_top
(
	input  wire logic                  clk,
	input  wire logic                  rst,
	input  wire logic                  cyc_i,
	input  wire logic                  stb_i,
	input  wire logic                  we_i,
	input  wire logic [4:0]            adr_i,
	input  wire logic [`PAM_BUS_W-1:0] dat_i,
	output logic [`PAM_BUS_W-1:0]      dat_o,
	output logic                       ack_o
);

	import pam_cmd_pkg::*;

	localparam int PAGE_W = $bits(page_t);

	// Slave to pools
	logic [`PAM_BANKS-1:0] cmd_valid;
	pam_op_e               cmd_op;
	page_t                 cmd_page;
	bank_id_t              rd_sel;

	// Pools to slave and collector
	logic [`PAM_BANKS-1:0]        bank_ready;
	logic [`PAM_BANKS-1:0]        bank_done;
	logic [`PAM_BANKS-1:0]        bank_full;
	logic [`PAM_BANKS-1:0]        bank_busy;
	logic [`PAM_BANKS*PAGE_W-1:0] bank_page;

	assign bank_busy = ~bank_ready;

	pam_wb_slave u_slave
	(
		.clk          (clk),
		.rst          (rst),
		.cyc_i        (cyc_i),
		.stb_i        (stb_i),
		.we_i         (we_i),
		.adr_i        (adr_i),
		.dat_i        (dat_i),
		.bank_ready_i (bank_ready),
		.bank_done_i  (bank_done),
		.ack_o        (ack_o),
		.cmd_valid_o  (cmd_valid),
		.cmd_op_o     (cmd_op),
		.cmd_page_o   (cmd_page),
		.rd_sel_o     (rd_sel)
	);

	// ======================================================================
	// Page pools
	// ======================================================================

	for (genvar b = 0; b < `PAM_BANKS; b++)
	begin : g_bank
		pam_bank u_bank
		(
			.clk         (clk),
			.rst         (rst),
			.cmd_valid_i (cmd_valid[b]),
			.cmd_op_i    (cmd_op),
			.cmd_page_i  (cmd_page),
			.ready_o     (bank_ready[b]),
			.done_o      (bank_done[b]),
			.page_o      (bank_page[b*PAGE_W +: PAGE_W]),
			.full_o      (bank_full[b])
		);
	end

	pam_result_collect u_collect
	(
		.clk      (clk),
		.rst      (rst),
		.done_i   (bank_done),
		.page_i   (bank_page),
		.full_i   (bank_full),
		.busy_i   (bank_busy),
		.rd_sel_i (rd_sel),
		.dat_o    (dat_o)
	);

endmodule

`default_nettype wire

//--- design/pam_wb_slave.sv
// Page allocator Wishbone slave
`timescale 1ns/1ps
`default_nettype none

`include "pam_consts.svh"

module pam_wb_slave
(
	input  wire logic                   clk,
	input  wire logic                   rst,
	input  wire logic                   cyc_i,
	input  wire logic                   stb_i,
	input  wire logic                   we_i,
	input  wire logic [4:0]             adr_i,
	input  wire logic [`PAM_BUS_W-1:0]  dat_i,
	input  wire logic [`PAM_BANKS-1:0]  bank_ready_i,
	input  wire logic [`PAM_BANKS-1:0]  bank_done_i,
	output logic                        ack_o,
	output logic [`PAM_BANKS-1:0]       cmd_valid_o,
	output pam_cmd_pkg::pam_op_e        cmd_op_o,
	output pam_cmd_pkg::page_t          cmd_page_o,
	output pam_cmd_pkg::bank_id_t       rd_sel_o
);

	import pam_cmd_pkg::*;

	// Transfer tracking, one command in flight at most
	typedef enum logic [1:0]
	{
		SL_IDLE,
		SL_WAIT_READY,
		SL_WAIT_DONE
	} slave_state_e;

	slave_state_e state;

	// Decoded view of the current bus request
	bank_id_t adr_bank;
	pam_reg_e adr_reg;
	pam_op_e  wr_op;
	logic     req;

	assign adr_bank = adr_i[4:3];
	assign adr_reg  = pam_reg_e'(adr_i[2]);
	assign wr_op    = pam_op_e'(dat_i[9:8]);

	// Master keeps stb_i up through the ack cycle, so mask that cycle out
	assign req = cyc_i && stb_i && !ack_o;

	// ======================================================================
	// Control FSM
	// ======================================================================

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			state       <= SL_IDLE;
			ack_o       <= 1'b0;
			cmd_valid_o <= '0;
			rd_sel_o    <= '0;
		end
		else
		begin
			// Ack and start are single-cycle pulses
			ack_o       <= 1'b0;
			cmd_valid_o <= '0;
			case (state)
			SL_IDLE:
				if (req)
				begin
					// Bank is latched for both reads and commands
					rd_sel_o <= adr_bank;
					if (we_i && adr_reg == REG_CMD && wr_op != OP_NOP)
						state <= SL_WAIT_READY;
					else
						// Reads, NOPs and RESULT writes finish next cycle
						ack_o <= 1'b1;
				end
			SL_WAIT_READY:
				// Only stalls while the pool runs its power-up clear
				if (bank_ready_i[rd_sel_o])
				begin
					cmd_valid_o[rd_sel_o] <= 1'b1;
					state                 <= SL_WAIT_DONE;
				end
			SL_WAIT_DONE:
				if (bank_done_i[rd_sel_o])
				begin
					ack_o <= 1'b1;
					state <= SL_IDLE;
				end
			default:
				state <= SL_IDLE;
			endcase
		end
	end

	// Command payload, shared by all banks
	always_ff @(posedge clk)
	begin
		if (state == SL_IDLE && req)
		begin
			cmd_op_o   <= wr_op;
			cmd_page_o <= dat_i[$bits(page_t)-1:0];
		end
	end

	// ======================================================================
	// Checks
	// ======================================================================

	// Master holds the cycle open until it has seen the ack
	a_ack_in_cycle: assert property (@(posedge clk) disable iff (rst)
		ack_o |-> cyc_i);

	// A start never lands on a pool that is still busy
	a_start_to_ready: assert property (@(posedge clk) disable iff (rst)
		(cmd_valid_o & ~bank_ready_i) == '0);

endmodule

`default_nettype wire

//--- files.f
+incdir+design
+incdir+tests
design/pam_cmd_pkg.sv
design/pam_bank_pkg.sv
design/pam_wb_slave.sv
design/pam_bank.sv
design/pam_result_collect.sv
design/pam_top.sv
tests/pam_tb.sv

//--- tests/pam_tb_model.svh
// Page pool reference model
`ifndef PAM_TB_MODEL_SVH
`define PAM_TB_MODEL_SVH

// Expected bitmap per bank, a set bit marks a page in use
logic [`PAM_WORD_BITS-1:0] model_map [`PAM_BANKS][`PAM_WORDS];

// Lowest word holding a free page, then the top free bit inside it
// Page 0 always counts as used, so page 0 back means the pool is full
function automatic page_t next_page(input bank_id_t b);
	logic [`PAM_WORD_BITS-1:0] w;
	logic                      hit;
	page_t                     p;
	hit = 1'b0;
	p   = '0;
	for (int i = 0; i < `PAM_WORDS; i++)
	begin
		w = model_map[b][i];
		if (i == 0)
			w[0] = 1'b1;
		// Walk down from the top bit, first clear one wins
		for (int n = `PAM_WORD_BITS - 1; n >= 0; n--)
		begin
			if (!hit && !w[n])
			begin
				hit = 1'b1;
				p   = page_t'(i * `PAM_WORD_BITS + n);
			end
		end
	end
	return p;
endfunction

// Upper bits pick the word, lower bits the bit in it
function automatic void model_mark(input bank_id_t b, input page_t p, input logic used);
	model_map[b][p[7:5]][p[4:0]] = used;
endfunction

// Whole pool free again
function automatic void model_wipe(input bank_id_t b);
	for (int i = 0; i < `PAM_WORDS; i++)
		model_map[b][i] = '0;
endfunction

`endif

//--- tests/pam_tb.sv
// Page allocator testbench
`timescale 1ns/1ps
`default_nettype none

`include "pam_consts.svh"

module pam_tb;

	import pam_cmd_pkg::*;

	// About 2000 operations at 40 cycles each
	localparam int TIMEOUT_CYCLES = 80000;

	logic                  clk;
	logic                  rst;
	logic                  cyc_i;
	logic                  stb_i;
	logic                  we_i;
	logic [4:0]            adr_i;
	logic [`PAM_BUS_W-1:0] dat_i;
	logic [`PAM_BUS_W-1:0] dat_o;
	logic                  ack_o;

	integer seed;
	int     cycles;

	// RESULT contents each bank should show
	page_t last_page [`PAM_BANKS];
	bit    last_full [`PAM_BANKS];

	// Reads waiting for the compare process
	bank_id_t cmp_bank_q [$];
	page_t    got_page_q [$];
	page_t    want_page_q [$];
	bit       got_full_q [$];
	bit       want_full_q [$];
	bit       got_busy_q [$];
	bit       want_busy_q [$];

	`include "pam_tb_model.svh"

	pam_top uut
	(
		.clk   (clk),
		.rst   (rst),
		.cyc_i (cyc_i),
		.stb_i (stb_i),
		.we_i  (we_i),
		.adr_i (adr_i),
		.dat_i (dat_i),
		.dat_o (dat_o),
		.ack_o (ack_o)
	);

	// 100 ns clock
	initial
	begin
		clk = 1'b0;
		forever
			#50 clk = ~clk;
	end

	// Run limit
	initial
	begin
		cycles = 0;
		forever
		begin
			@(posedge clk);
			cycles++;
			if (cycles >= TIMEOUT_CYCLES)
			begin
				$display("run still going after %0d cycles, bus or bank hung", cycles);
				$display("Test failed");
				$fatal(1, "timeout");
			end
		end
	end

	// ======================================================================
	// Checks
	// ======================================================================

	task automatic report_mismatch(input string what, input logic [31:0] got,
		input logic [31:0] want);
		$display("mismatch at time %0t: %s got %0d, expected %0d", $time, what, got, want);
		$display("Test failed");
		$fatal(1, "result check failed");
	endtask

	task automatic check_page(input bank_id_t b, input page_t got, input page_t want);
		if (got !== want)
			report_mismatch($sformatf("bank %0d dat_o page", b), 32'(got), 32'(want));
	endtask

	task automatic check_flag(input string what, input bank_id_t b, input bit got,
		input bit want);
		if (got !== want)
			report_mismatch($sformatf("bank %0d dat_o %s", b, what), 32'(got), 32'(want));
	endtask

	// Compare process, drains whatever the stimulus has read back
	initial
	begin
		bank_id_t b;
		forever
		begin
			@(negedge clk);
			while (got_page_q.size() > 0)
			begin
				b = cmp_bank_q.pop_front();
				check_page(b, got_page_q.pop_front(), want_page_q.pop_front());
				check_flag("full", b, got_full_q.pop_front(), want_full_q.pop_front());
				check_flag("busy", b, got_busy_q.pop_front(), want_busy_q.pop_front());
			end
		end
	end

	// ======================================================================
	// Bus access
	// ======================================================================

	// Inputs change on the falling edge only
	task automatic bus_cycle(input logic we, input logic [4:0] adr,
		input logic [`PAM_BUS_W-1:0] wdata, output logic [`PAM_BUS_W-1:0] rdata);
		@(negedge clk);
		cyc_i = 1'b1;
		stb_i = 1'b1;
		we_i  = we;
		adr_i = adr;
		dat_i = wdata;
		@(negedge clk);
		while (!ack_o)
			@(negedge clk);
		rdata = dat_o;
		// Request stays up across the ack edge
		@(negedge clk);
		// Ack lasts exactly one cycle per transfer
		if (ack_o !== 1'b0)
			report_mismatch("ack_o pulse", 32'(ack_o), 32'(0));
		cyc_i = 1'b0;
		stb_i = 1'b0;
		we_i  = 1'b0;
	endtask

	task automatic bus_write(input logic [4:0] adr, input logic [`PAM_BUS_W-1:0] wdata);
		logic [`PAM_BUS_W-1:0] unused_rd;
		bus_cycle(1'b1, adr, wdata, unused_rd);
	endtask

	task automatic bus_read(input logic [4:0] adr, output logic [`PAM_BUS_W-1:0] rdata);
		bus_cycle(1'b0, adr, '0, rdata);
	endtask

	function automatic logic [4:0] reg_adr(input bank_id_t b, input pam_reg_e r);
		return {b, r, 2'b00};
	endfunction

	// Opcode in bits 9:8, page in 7:0
	function automatic logic [`PAM_BUS_W-1:0] cmd_word(input pam_op_e op, input page_t p);
		logic [`PAM_BUS_W-1:0] w;
		w      = '0;
		w[9:8] = op;
		w[7:0] = p;
		return w;
	endfunction

	// ======================================================================
	// Operations
	// ======================================================================

	task automatic read_result(input bank_id_t b, input bit want_busy);
		logic [`PAM_BUS_W-1:0] d;
		bus_read(reg_adr(b, REG_RESULT), d);
		cmp_bank_q.push_back(b);
		got_page_q.push_back(d[7:0]);
		want_page_q.push_back(last_page[b]);
		got_full_q.push_back(d[8]);
		want_full_q.push_back(last_full[b]);
		got_busy_q.push_back(d[9]);
		want_busy_q.push_back(want_busy);
	endtask

	task automatic alloc_page(input bank_id_t b);
		page_t want;
		want = next_page(b);
		bus_write(reg_adr(b, REG_CMD), cmd_word(OP_ALLOC, '0));
		if (want != '0)
			model_mark(b, want, 1'b1);
		last_page[b] = want;
		last_full[b] = (want == '0);
		read_result(b, 1'b0);
	endtask

	// Result register keeps the last allocation
	task automatic free_page(input bank_id_t b, input page_t p);
		bus_write(reg_adr(b, REG_CMD), cmd_word(OP_FREE, p));
		model_mark(b, p, 1'b0);
		read_result(b, 1'b0);
	endtask

	task automatic free_all(input bank_id_t b);
		bus_write(reg_adr(b, REG_CMD), cmd_word(OP_FREEALL, '0));
		model_wipe(b);
		last_page[b] = '0;
		last_full[b] = 1'b0;
		read_result(b, 1'b0);
	endtask

	// Random page in use, or 0 when none was hit
	function automatic page_t pick_used(input bank_id_t b);
		logic [31:0] r;
		page_t       p;
		page_t       hit;
		hit = '0;
		for (int t = 0; t < 256; t++)
		begin
			r = $random(seed);
			p = r[7:0];
			if (hit == '0 && p != '0 && model_map[b][p[7:5]][p[4:0]])
				hit = p;
		end
		return hit;
	endfunction

	// ======================================================================
	// Stimulus
	// ======================================================================

	initial
	begin
		page_t       p;
		bank_id_t    b;
		logic [31:0] r;
		seed  = 32'h99d6_6b34;
		rst   = 1'b1;
		cyc_i = 1'b0;
		stb_i = 1'b0;
		we_i  = 1'b0;
		adr_i = '0;
		dat_i = '0;
		for (int i = 0; i < `PAM_BANKS; i++)
		begin
			model_wipe(bank_id_t'(i));
			last_page[i] = '0;
			last_full[i] = 1'b0;
		end
		// Three rising edges in reset, release on the falling edge
		repeat (3) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;

		// Pool still in its power-up clear
		read_result(bank_id_t'(0), 1'b1);

		// Fresh pool gives 31 down to 1, then 63
		repeat (32) alloc_page(bank_id_t'(0));

		// Free a used page, the next allocate takes it back
		repeat (20)
		begin
			p = pick_used(bank_id_t'(0));
			if (p != '0)
				free_page(bank_id_t'(0), p);
			alloc_page(bank_id_t'(0));
		end

		// 255 real pages, then page 0 with full set
		repeat (`PAM_PAGES) alloc_page(bank_id_t'(1));

		// Empty pool again
		free_all(bank_id_t'(1));
		alloc_page(bank_id_t'(1));

		// Mixed traffic over all banks
		repeat (600)
		begin
			r = $random(seed);
			b = bank_id_t'(r[1:0]);
			case (r[4:2])
			3'd0:
				free_all(b);
			3'd1,
			3'd2:
			begin
				p = pick_used(b);
				if (p != '0)
					free_page(b, p);
				else
					alloc_page(b);
			end
			default:
				alloc_page(b);
			endcase
		end

		while (got_page_q.size() != 0)
			@(negedge clk);
		@(negedge clk);
		$display("Test completed successfully");
		$finish;
	end

endmodule

`default_nettype wire
